// ==== Makefile ====
TOP = ooo_core_tb

all: run

build:
	verilator --binary --timing --assert -f ooo_core.f --top-module $(TOP) -Mdir obj_dir

# pass only when the simulation printed the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -f ooo_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode import ooo_pkg::*; (
  input  wire inst_u i_inst,
  output decoded_t   o_dec
);

  logic is_r, is_i;
  logic base_f7, alt_f7;
  logic is_shift;

  assign is_r     = i_inst.r.opcode == OPC_OP;
  assign is_i     = i_inst.i.opcode == OPC_OPIMM;
  assign base_f7  = i_inst.r.funct7 == 7'b0000000; // also imm12[11:5] for op-imm
  assign alt_f7   = i_inst.r.funct7 == 7'b0100000;
  assign is_shift = i_inst.r.funct3 == 3'b001 || i_inst.r.funct3 == 3'b101;

  always_comb begin
    o_dec.rd      = i_inst.r.rd;
    o_dec.rs1     = i_inst.r.rs1;
    o_dec.rs2     = i_inst.r.rs2;
    o_dec.use_imm = is_i;
    o_dec.imm     = {{20{i_inst.i.imm12[11]}}, i_inst.i.imm12};

    // alt funct7 only valid for sub/sra, and for srai on the immediate side
    if (is_r) begin
      o_dec.legal = base_f7 || (alt_f7 && (i_inst.r.funct3 == 3'b000 ||
                                           i_inst.r.funct3 == 3'b101));
    end else if (is_i) begin
      o_dec.legal = !is_shift || base_f7 || (alt_f7 && i_inst.i.funct3 == 3'b101);
    end else begin
      o_dec.legal = 1'b0; // everything else is dropped
    end

    case (i_inst.r.funct3)
      3'b000:  o_dec.op = (is_r && alt_f7) ? ALU_SUB : ALU_ADD; // no subi
      3'b001:  o_dec.op = ALU_SLL;
      3'b010:  o_dec.op = ALU_SLT;
      3'b011:  o_dec.op = ALU_SLTU;
      3'b100:  o_dec.op = ALU_XOR;
      3'b101:  o_dec.op = alt_f7 ? ALU_SRA : ALU_SRL;
      3'b110:  o_dec.op = ALU_OR;
      default: o_dec.op = ALU_AND;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu import ooo_pkg::*; (
  input  wire       clk_100mhz,
  input  wire       sys_rst,
  input  wire logic i_valid,
  input  wire uop_t i_uop,
  output cdb_t      o_cdb
);

  word_t a, b, result;

  assign a = i_uop.src1.val;
  assign b = i_uop.src2.val;

  always_comb begin
    case (i_uop.op)
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << b[4:0]; // only low five bits shift
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> b[4:0];
      ALU_SRA:  result = $signed(a) >>> b[4:0];
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = a + b;
    endcase
  end

  // one cycle broadcast
  always_ff @(posedge clk_100mhz) begin
    o_cdb.tag   <= i_uop.dst;
    o_cdb.value <= result;
    if (sys_rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= i_valid;
    end
  end

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH  = 3
) (
  input  wire        clk_100mhz,
  input  wire        sys_rst,
  input  wire logic  i_inst_valid,
  input  wire word_t i_inst,
  output logic       o_issue_ready,
  output commit_t    o_commit
);

  inst_u    inst_w;
  decoded_t dec;
  logic     rob_full, rs_full, accept, alloc;
  tag_t     alloc_tag, commit_tag;
  operand_t rf_src1, rf_src2, rob_q1, rob_q2;
  operand_t src1, src2;
  uop_t     issue_uop, disp_uop;
  logic     dispatch;
  cdb_t     cdb;

  assign inst_w        = i_inst;
  assign o_issue_ready = !rob_full && !rs_full; // registered state only
  assign accept        = i_inst_valid && o_issue_ready;
  assign alloc         = accept && dec.legal; // illegal words vanish here

  inst_decode u_dec (.i_inst(inst_w), .o_dec(dec));

  tag_regfile u_rf (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1(dec.rs1), .i_rs2(dec.rs2),
    .i_rename(alloc), .i_rename_rd(dec.rd), .i_rename_tag(alloc_tag),
    .i_commit(o_commit), .i_commit_tag(commit_tag),
    .o_src1(rf_src1), .o_src2(rf_src2)
  );

  // busy source falls back to the rob, immediate always ready
  always_comb begin
    src1 = rf_src1.rdy ? rf_src1 : rob_q1;
    if (dec.use_imm) begin
      src2.rdy = 1'b1;
      src2.tag = '0;
      src2.val = dec.imm;
    end else begin
      src2 = rf_src2.rdy ? rf_src2 : rob_q2;
    end
    issue_uop.op   = dec.op;
    issue_uop.dst  = alloc_tag;
    issue_uop.src1 = src1;
    issue_uop.src2 = src2;
  end

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alloc(alloc), .i_alloc_rd(dec.rd),
    .i_query1(rf_src1.tag), .i_query2(rf_src2.tag), .i_cdb(cdb),
    .o_alloc_tag(alloc_tag), .o_full(rob_full),
    .o_query1(rob_q1), .o_query2(rob_q2),
    .o_commit(o_commit), .o_commit_tag(commit_tag)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_write(alloc), .i_uop(issue_uop), .i_cdb(cdb),
    .o_full(rs_full), .o_dispatch(dispatch), .o_uop(disp_uop)
  );

  int_alu u_alu (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_valid(dispatch), .i_uop(disp_uop), .o_cdb(cdb)
  );

endmodule

`default_nettype wire

// ==== design/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

  localparam int TAG_W = 4; // enough for 16 rob entries

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [4:0]       reg_idx_t;
  typedef logic [31:0]      word_t;

  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediate layout, imm12[11:5] overlays funct7
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

  typedef struct packed {
    logic     legal;
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_imm;
    word_t    imm; // sign extended
  } decoded_t;

  typedef struct packed {
    logic  rdy;
    tag_t  tag; // producer while not ready
    word_t val;
  } operand_t;

  typedef struct packed {
    alu_op_e  op;
    tag_t     dst;
    operand_t src1;
    operand_t src2;
  } uop_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
  } cdb_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    value;
  } commit_t;

endpackage

`default_nettype wire

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire           clk_100mhz,
  input  wire           sys_rst,
  input  wire logic     i_alloc,
  input  wire reg_idx_t i_alloc_rd,
  input  wire tag_t     i_query1,
  input  wire tag_t     i_query2,
  input  wire cdb_t     i_cdb,
  output tag_t          o_alloc_tag,
  output logic          o_full,
  output operand_t      o_query1,
  output operand_t      o_query2,
  output commit_t       o_commit,
  output tag_t          o_commit_tag
);

  localparam int IDX_W = $clog2(ROB_DEPTH);

  logic [IDX_W-1:0] head, tail;
  logic [IDX_W:0]   count;
  logic [ROB_DEPTH-1:0] vld, done;
  reg_idx_t         rd_q  [ROB_DEPTH];
  word_t            val_q [ROB_DEPTH];
  logic             retire;

  function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] p);
    return (p == IDX_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // finished entry first, then whatever the bus carries this cycle
  function automatic operand_t lookup(input tag_t q);
    operand_t         res;
    logic [IDX_W-1:0] idx;
    idx     = q[IDX_W-1:0];
    res.rdy = 1'b0;
    res.tag = q;
    res.val = '0;
    if (vld[idx] && done[idx]) begin
      res.rdy = 1'b1;
      res.val = val_q[idx];
    end else if (i_cdb.valid && i_cdb.tag == q) begin
      res.rdy = 1'b1;
      res.val = i_cdb.value;
    end
    return res;
  endfunction

  assign o_query1 = lookup(i_query1);
  assign o_query2 = lookup(i_query2);

  assign o_full       = count == (IDX_W + 1)'(ROB_DEPTH);
  assign o_alloc_tag  = tag_t'(tail);
  assign o_commit_tag = tag_t'(head);
  assign retire       = vld[head] && done[head];

  always_comb begin
    o_commit.valid = retire;
    o_commit.rd    = rd_q[head];
    o_commit.value = val_q[head];
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      vld   <= '0;
      done  <= '0;
    end else begin
      if (i_cdb.valid) begin
        done[i_cdb.tag[IDX_W-1:0]] <= 1'b1;
      end
      if (retire) begin
        vld[head]  <= 1'b0;
        done[head] <= 1'b0;
        head       <= next_ptr(head);
      end
      if (i_alloc) begin
        vld[tail]  <= 1'b1;
        done[tail] <= 1'b0;
        tail       <= next_ptr(tail);
      end
      count <= count + (IDX_W + 1)'(i_alloc) - (IDX_W + 1)'(retire);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      rd_q[tail] <= i_alloc_rd;
    end
    if (i_cdb.valid) begin
      val_q[i_cdb.tag[IDX_W-1:0]] <= i_cdb.value;
    end
  end

  a_no_alloc_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_alloc |-> !o_full)
    else $error("allocation while reorder buffer full");

  // alu results only ever target live entries
  a_cdb_live: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_cdb.valid |-> (int'(i_cdb.tag) < ROB_DEPTH && vld[i_cdb.tag[IDX_W-1:0]]))
    else $error("bus write to free rob entry %0d", i_cdb.tag);

endmodule

`default_nettype wire

// ==== design/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; #(
  parameter int RS_DEPTH = 3
) (
  input  wire       clk_100mhz,
  input  wire       sys_rst,
  input  wire logic i_write,
  input  wire uop_t i_uop,
  input  wire cdb_t i_cdb,
  output logic      o_full,
  output logic      o_dispatch,
  output uop_t      o_uop
);

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  uop_t              ent [RS_DEPTH];
  logic [RS_DEPTH-1:0] vld;
  logic [IDX_W-1:0]  age [RS_DEPTH]; // number of younger valid entries
  logic [IDX_W-1:0]  sel, wsel;

  function automatic operand_t snoop(input operand_t op, input cdb_t bus);
    operand_t res;
    res = op;
    if (!op.rdy && bus.valid && bus.tag == op.tag) begin
      res.rdy = 1'b1;
      res.val = bus.value;
    end
    return res;
  endfunction

  // oldest entry with both operands in hand
  always_comb begin
    o_dispatch = 1'b0;
    sel        = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (vld[i] && ent[i].src1.rdy && ent[i].src2.rdy &&
          (!o_dispatch || age[i] > age[sel])) begin
        o_dispatch = 1'b1;
        sel        = IDX_W'(i);
      end
    end
  end

  always_comb begin
    wsel = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!vld[i]) begin
        wsel = IDX_W'(i); // lowest free slot
      end
    end
  end

  assign o_full = &vld;
  assign o_uop  = ent[sel];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      vld <= '0;
      for (int i = 0; i < RS_DEPTH; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (vld[i]) begin
          // older entries lose one younger neighbour when sel leaves
          age[i] <= age[i] + IDX_W'(i_write) -
                    IDX_W'(o_dispatch && age[i] > age[sel]);
        end
      end
      if (o_dispatch) begin
        vld[sel] <= 1'b0;
      end
      if (i_write) begin
        vld[wsel] <= 1'b1;
        age[wsel] <= '0;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (i_write && wsel == IDX_W'(i)) begin
        ent[i] <= i_uop;
      end else begin
        ent[i].src1 <= snoop(ent[i].src1, i_cdb);
        ent[i].src2 <= snoop(ent[i].src2, i_cdb);
      end
    end
  end

  // a new entry never waits on the broadcast happening as it is written
  a_no_missed_bus: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (i_write && i_cdb.valid) |->
      ((i_uop.src1.rdy || i_uop.src1.tag != i_cdb.tag) &&
       (i_uop.src2.rdy || i_uop.src2.tag != i_cdb.tag)))
    else $error("operand of tag %0d waits on tag %0d already on the bus",
                i_uop.dst, i_cdb.tag);

endmodule

`default_nettype wire

// ==== design/tag_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_regfile import ooo_pkg::*; (
  input  wire           clk_100mhz,
  input  wire           sys_rst,
  input  wire reg_idx_t i_rs1,
  input  wire reg_idx_t i_rs2,
  input  wire logic     i_rename,
  input  wire reg_idx_t i_rename_rd,
  input  wire tag_t     i_rename_tag,
  input  wire commit_t  i_commit,
  input  wire tag_t     i_commit_tag,
  output operand_t      o_src1,
  output operand_t      o_src2
);

  word_t       regs [32];
  tag_t        tags [32];
  logic [31:0] busy;

  // busy registers hand back their pending tag for the rob lookup
  function automatic operand_t read_src(input reg_idx_t rs);
    operand_t res;
    logic     fwd;
    fwd = i_commit.valid && rs != '0 && i_commit.rd == rs &&
          tags[rs] == i_commit_tag; // retiring producer, take its value now
    res.tag = tags[rs];
    res.rdy = !busy[rs] || fwd;
    res.val = fwd ? i_commit.value : regs[rs];
    return res;
  endfunction

  assign o_src1 = read_src(i_rs1);
  assign o_src2 = read_src(i_rs2);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      if (i_commit.valid && i_commit.rd != '0) begin
        regs[i_commit.rd] <= i_commit.value;
        // an older producer retiring leaves a newer rename in place
        if (tags[i_commit.rd] == i_commit_tag) begin
          busy[i_commit.rd] <= 1'b0;
        end
      end
      if (i_rename && i_rename_rd != '0) begin // x0 stays zero
        busy[i_rename_rd] <= 1'b1; // wins over a same cycle commit
        tags[i_rename_rd] <= i_rename_tag;
      end
    end
  end

  // every retiring write was renamed at issue and is still outstanding
  a_commit_busy: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (i_commit.valid && i_commit.rd != '0) |-> busy[i_commit.rd])
    else $error("commit to x%0d which has no pending rename", i_commit.rd);

endmodule

`default_nettype wire

// ==== ooo_core.f ====
design/ooo_pkg.sv
design/inst_decode.sv
design/tag_regfile.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/int_alu.sv
design/ooo_core.sv
tests/ooo_core_tb.sv

// ==== tests/ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

  localparam int N_RESET   = 1;
  localparam int N_FUNC    = 7 + 19; // setup writes plus every r and i form
  localparam int N_CHAIN   = 24;
  localparam int N_RANDOM  = 120;
  localparam int N_BURST   = 40;
  localparam int N_PLANNED = N_RESET + N_FUNC + N_CHAIN + N_RANDOM + N_BURST;
  localparam int TIMEOUT_CYCLES = 20 * N_PLANNED + 200;

  logic    clk_100mhz, sys_rst, i_inst_valid, o_issue_ready;
  word_t   i_inst;
  commit_t o_commit;

  // what the word on the port means to the model
  logic     cur_legal, cur_use_imm;
  alu_op_e  cur_op;
  reg_idx_t cur_rd, cur_rs1, cur_rs2;
  word_t    cur_imm; // second operand when use_imm

  word_t       model_regs [32];
  commit_t     exp_mem [512]; // expected commits, oldest at rd_ptr
  logic [8:0]  wr_ptr, rd_ptr;
  commit_t     exp_head;
  word_t       exp_now;
  logic        seen_legal, saw_stall;
  logic [31:0] lfsr = 32'h27fd0963;
  int          commit_count, legal_count, illegal_count;
  int          err_count = 0;
  int          issued = 0;
  int          cycles = 0;

  ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(3)) DUT (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_issue_ready(o_issue_ready), .o_commit(o_commit)
  );

  function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_OR:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  assign exp_head = exp_mem[rd_ptr];
  assign exp_now  = ref_alu(cur_op, model_regs[cur_rs1],
                            cur_use_imm ? cur_imm : model_regs[cur_rs2]);

  // architectural model, applied in acceptance order
  always @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] <= '0;
      end
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      seen_legal    <= 1'b0;
      commit_count  <= 0;
      legal_count   <= 0;
      illegal_count <= 0;
    end else begin
      if (i_inst_valid && o_issue_ready) begin
        if (cur_legal) begin
          exp_mem[wr_ptr] <= {1'b1, cur_rd, exp_now};
          wr_ptr          <= wr_ptr + 1'b1;
          legal_count     <= legal_count + 1;
          seen_legal      <= 1'b1;
          if (cur_rd != '0) begin
            model_regs[cur_rd] <= exp_now; // x0 stays zero
          end
        end else begin
          illegal_count <= illegal_count + 1;
        end
      end
      if (o_commit.valid) begin
        rd_ptr       <= rd_ptr + 1'b1;
        commit_count <= commit_count + 1;
      end
    end
  end

  always @(posedge clk_100mhz) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  a_ready_after_reset: assert property (@(posedge clk_100mhz)
    $fell(sys_rst) |-> o_issue_ready)
    else begin
      $display("o_issue_ready was low in the first cycle after reset");
      err_count++;
    end

  a_no_early_commit: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit.valid |-> seen_legal)
    else begin
      $display("commit at %0t before any legal instruction was accepted", $time);
      err_count++;
    end

  a_commit_known: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit.valid |-> rd_ptr != wr_ptr)
    else begin
      $display("commit at %0t with no accepted instruction outstanding", $time);
      err_count++;
    end

  a_commit_rd: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (o_commit.valid && rd_ptr != wr_ptr) |-> o_commit.rd == exp_head.rd)
    else begin
      $display("ERROR at %0t: o_commit.rd expected %0d actual %0d", $time,
               $sampled(exp_head.rd), $sampled(o_commit.rd));
      err_count++;
    end

  a_commit_value: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (o_commit.valid && rd_ptr != wr_ptr) |-> o_commit.value == exp_head.value)
    else begin
      $display("ERROR at %0t: o_commit.value expected %h actual %h", $time,
               $sampled(exp_head.value), $sampled(o_commit.value));
      err_count++;
    end

  // holds the word until the core takes it
  task automatic drive(input word_t w, input logic legal, input alu_op_e op,
                       input logic use_imm, input reg_idx_t rd, input reg_idx_t rs1,
                       input reg_idx_t rs2, input word_t b);
    @(negedge clk_100mhz);
    i_inst       = w;
    i_inst_valid = 1'b1;
    cur_legal    = legal;
    cur_op       = op;
    cur_use_imm  = use_imm;
    cur_rd       = rd;
    cur_rs1      = rs1;
    cur_rs2      = rs2;
    cur_imm      = b;
    while (!o_issue_ready) begin
      saw_stall = 1'b1;
      @(negedge clk_100mhz);
    end
    issued++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_100mhz);
      i_inst_valid = 1'b0;
      cur_legal    = 1'b0;
    end
  endtask

  task automatic issue_op(input alu_op_e op, input logic use_imm, input reg_idx_t rd,
                          input reg_idx_t rs1, input reg_idx_t rs2, input logic [11:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       shift;
    word_t      w;
    word_t      b;
    f7    = (op == ALU_SUB || op == ALU_SRA) ? 7'b0100000 : 7'b0000000;
    shift = op == ALU_SLL || op == ALU_SRL || op == ALU_SRA;
    case (op)
      ALU_SLL:          f3 = 3'b001;
      ALU_SLT:          f3 = 3'b010;
      ALU_SLTU:         f3 = 3'b011;
      ALU_XOR:          f3 = 3'b100;
      ALU_SRL, ALU_SRA: f3 = 3'b101;
      ALU_OR:           f3 = 3'b110;
      ALU_AND:          f3 = 3'b111;
      default:          f3 = 3'b000;
    endcase
    if (use_imm && shift) begin
      w = {f7, imm[4:0], rs1, f3, rd, OPC_OPIMM}; // shamt form
      b = {27'b0, imm[4:0]};
    end else if (use_imm) begin
      w = {imm, rs1, f3, rd, OPC_OPIMM};
      b = {{20{imm[11]}}, imm};
    end else begin
      w = {f7, rs2, rs1, f3, rd, OPC_OP};
      b = '0;
    end
    drive(w, 1'b1, op, use_imm, rd, rs1, rs2, b);
  endtask

  // mul or lui, neither of which the core executes
  task automatic issue_illegal();
    logic [31:0] r;
    logic [31:0] u;
    word_t       w;
    take_bits(1, r);
    take_bits(20, u);
    w = r[0] ? {7'b0000001, u[9:0], 3'b000, 5'd3, OPC_OP} : {u[19:0], 5'd4, 7'b0110111};
    drive(w, 1'b0, ALU_ADD, 1'b0, '0, '0, '0, '0);
  endtask

  task automatic pick_op(output alu_op_e op, output logic use_imm, output logic [11:0] imm);
    logic [31:0] r;
    logic [3:0]  code;
    take_bits(4, r);
    code = 4'(r % 10);
    op   = alu_op_e'(code);
    take_bits(1, r);
    use_imm = r[0] && op != ALU_SUB; // there is no subi
    take_bits(12, r);
    imm = r[11:0];
  endtask

  task automatic pick_reg(output reg_idx_t rg);
    logic [31:0] r;
    take_bits(3, r);
    rg = reg_idx_t'(r % 6); // x0..x5 keeps dependencies frequent
  endtask

  task automatic report(input string name);
    $display("test %-10s done: %0d words issued, %0d errors so far", name, issued, err_count);
  endtask

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  initial begin
    logic [31:0] r;
    alu_op_e     op;
    logic        use_imm;
    logic [11:0] imm;
    reg_idx_t    rd, rs1, rs2, prev;
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    cur_legal    = 1'b0;
    cur_use_imm  = 1'b0;
    cur_op       = ALU_ADD;
    cur_rd       = '0;
    cur_rs1      = '0;
    cur_rs2      = '0;
    cur_imm      = '0;
    saw_stall    = 1'b0;
    repeat (5) @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    sys_rst = 1'b0;

    // quiet start, an illegal word must not wake the commit port
    idle(4);
    issue_illegal();
    idle(6);
    report("reset");

    for (int k = 1; k <= 7; k++) begin
      take_bits(12, r);
      issue_op(ALU_ADD, 1'b1, reg_idx_t'(k), '0, '0, r[11:0]);
    end
    for (int k = 0; k < 10; k++) begin
      op = alu_op_e'(4'(k));
      pick_reg(rd);
      pick_reg(rs1);
      pick_reg(rs2);
      take_bits(12, r);
      issue_op(op, 1'b0, rd + 1'b1, rs1 + 1'b1, rs2 + 1'b1, r[11:0]);
      if (op != ALU_SUB) begin
        issue_op(op, 1'b1, rs2 + 1'b1, rd + 1'b1, '0, r[11:0]);
      end
    end
    idle(1);
    report("functions");

    prev = 5'd1;
    for (int k = 0; k < N_CHAIN; k++) begin
      pick_op(op, use_imm, imm);
      rd = (k % 6 == 5) ? 5'd0 : reg_idx_t'(1 + k % 3); // every sixth writes x0
      issue_op(op, use_imm, rd, prev, prev, imm);
      prev = rd;
    end
    idle(1);
    report("chains");

    for (int k = 0; k < N_RANDOM; k++) begin
      take_bits(5, r);
      if (r < 2) begin
        issue_illegal();
      end else begin
        pick_op(op, use_imm, imm);
        pick_reg(rd);
        pick_reg(rs1);
        pick_reg(rs2);
        issue_op(op, use_imm, rd, rs1, rs2, imm);
      end
      take_bits(2, r);
      if (r == 3) begin
        take_bits(2, r);
        idle(r);
      end
    end
    idle(1);
    report("random");

    // a dependent stream with no gaps fills the station
    saw_stall = 1'b0;
    prev      = 5'd2;
    for (int k = 0; k < N_BURST; k++) begin
      pick_op(op, use_imm, imm);
      pick_reg(rs2);
      rd = reg_idx_t'(1 + k % 4);
      issue_op(op, use_imm, rd, prev, rs2, imm);
      prev = rd;
    end
    idle(1);
    assert (saw_stall) else begin
      $display("o_issue_ready never fell during the dense burst");
      err_count++;
    end
    report("burst");

    while (rd_ptr != wr_ptr) begin
      @(negedge clk_100mhz);
    end
    idle(10);
    assert (commit_count == legal_count) else begin
      $display("%0d legal words accepted but %0d commits seen", legal_count, commit_count);
      err_count++;
    end
    assert (rd_ptr == wr_ptr) else begin
      $display("expected commits still outstanding at the end of the run");
      err_count++;
    end
    report("drain");

    $display("summary: %0d commits, %0d legal and %0d illegal accepted, %0d errors",
             commit_count, legal_count, illegal_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
